// ==== vlog.f ====
+incdir+include
source/fetch_pkg.sv
source/fetch_fifo.sv
source/if_id.sv
source/pc_counter.sv
source/fetch_ctrl.sv
source/fetch_unit.sv
bench/fetch_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f vlog.f --top-module fetch_unit_tb -o fetch_sim \
    > "$LOG" 2>&1 \
    && ./obj_dir/fetch_sim >> "$LOG" 2>&1 \
    || echo "Testbench failed" >> "$LOG"

cat "$LOG"
grep -q "Testbench failed" "$LOG" && { echo "simulation FAILED"; exit 1; }
echo "simulation ok"
exit 0

// ==== bench/fetch_unit_tb.sv ====
/* fetch front end testbench
   table-driven phases checked against a reference queue of expected entries */

`default_nettype none

`include "fetch_config.svh"

module fetch_unit_tb;

    import fetch_pkg::*;

    localparam int    DEPTH     = `FETCH_BUF_DEPTH;
    localparam addr_t RESET_PC  = 32'h0000_0100; // first fetch after reset
    localparam inst_t WORD_MASK = 32'hA5A5_0000; // memory word is addr ^ mask
    localparam int    N_ROWS    = 16;
    localparam int    DRAIN_MAX = 20;            // cycles allowed to empty the buffer

    localparam logic [1:0] DEC_LOW  = 2'd0; // decode ready patterns
    localparam logic [1:0] DEC_HIGH = 2'd1;
    localparam logic [1:0] DEC_ALT  = 2'd2;
    localparam logic [1:0] DEC_RAND = 2'd3;

    logic     clk;
    logic     rst;
    hold_e    hold;
    logic     jump;
    addr_t    jump_addr;
    int_vec_t irq;
    logic     mem_ready;
    inst_t    mem_rdata;
    logic     dec_ready;
    logic     req;
    addr_t    req_addr;
    logic     valid;
    inst_t    inst;
    addr_t    inst_addr;
    logic     after_jump;
    int_vec_t int_flag;

    // stimulus table, one row per phase
    hold_e      row_hold     [N_ROWS];
    logic       row_jump     [N_ROWS]; // pulse on first cycle of the row
    addr_t      row_target   [N_ROWS];
    logic [1:0] row_dec      [N_ROWS];
    logic       row_mem_rand [N_ROWS]; // 0 means memory always ready
    int         row_cycles   [N_ROWS];

    // reference model state
    inst_t    exp_inst_q [$];
    addr_t    exp_addr_q [$];
    logic     exp_aj_q   [$];
    int_vec_t exp_int_q  [$];
    addr_t    ref_pc;
    logic     ref_aj;     // next accepted fetch is a jump target
    logic [31:0] lcg_state;
    int       delivered;
    int       aj_seen;

    fetch_unit dut_i (
        .clk_i        (clk),
        .rst_i        (rst),
        .hold_i       (hold),
        .jump_i       (jump),
        .jump_addr_i  (jump_addr),
        .int_i        (irq),
        .instr_ready_i(mem_ready),
        .instr_rdata_i(mem_rdata),
        .ready_i      (dec_ready),
        .instr_req_o  (req),
        .instr_addr_o (req_addr),
        .valid_o      (valid),
        .inst_o       (inst),
        .inst_addr_o  (inst_addr),
        .after_jump_o (after_jump),
        .int_flag_o   (int_flag)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk; // 20 unit period

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_inst(input inst_t got, input inst_t exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_int(input int_vec_t got, input int_vec_t exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic set_row(input int idx, input hold_e h, input logic j, input addr_t t,
                           input logic [1:0] d, input logic m, input int n);
        row_hold[idx]     = h;
        row_jump[idx]     = j;
        row_target[idx]   = t;
        row_dec[idx]      = d;
        row_mem_rand[idx] = m;
        row_cycles[idx]   = n;
    endtask

    task automatic load_table();
        set_row(0,  HOLD_NONE,  1'b0, '0,            DEC_HIGH, 1'b0, 12); // streaming
        set_row(1,  HOLD_NONE,  1'b0, '0,            DEC_LOW,  1'b0, 6);  // back-pressure
        set_row(2,  HOLD_NONE,  1'b0, '0,            DEC_HIGH, 1'b0, 6);
        set_row(3,  HOLD_NONE,  1'b0, '0,            DEC_LOW,  1'b0, 3);
        set_row(4,  HOLD_NONE,  1'b1, 32'h0000_2000, DEC_LOW,  1'b0, 1);  // jump over full buf
        set_row(5,  HOLD_NONE,  1'b0, '0,            DEC_HIGH, 1'b0, 8);
        set_row(6,  HOLD_NONE,  1'b0, '0,            DEC_LOW,  1'b0, 3);
        set_row(7,  HOLD_PC,    1'b0, '0,            DEC_LOW,  1'b0, 3);  // stall, keep entries
        set_row(8,  HOLD_PC,    1'b0, '0,            DEC_HIGH, 1'b0, 4);
        set_row(9,  HOLD_NONE,  1'b0, '0,            DEC_LOW,  1'b0, 3);
        set_row(10, HOLD_CLEAR, 1'b0, '0,            DEC_LOW,  1'b0, 1);  // drop buffer
        set_row(11, HOLD_NONE,  1'b0, '0,            DEC_HIGH, 1'b0, 6);
        set_row(12, HOLD_NONE,  1'b0, '0,            DEC_RAND, 1'b1, 60); // random ready
        set_row(13, HOLD_NONE,  1'b1, 32'h0000_4000, DEC_RAND, 1'b1, 1);
        set_row(14, HOLD_NONE,  1'b0, '0,            DEC_ALT,  1'b1, 40);
        set_row(15, HOLD_NONE,  1'b0, '0,            DEC_HIGH, 1'b0, 6);
    endtask

    // model one clock of the front end from the driven inputs
    task automatic check_cycle();
        logic     exp_req;
        inst_t    e_inst;
        addr_t    e_addr;
        logic     e_aj;
        int_vec_t e_int;
        exp_req = (hold == HOLD_NONE) && !jump && (exp_inst_q.size() < DEPTH);
        check_bit(req, exp_req, "instr_req_o");
        check_bit(valid, exp_inst_q.size() != 0, "valid_o"); // one cycle after accept
        if (exp_req) begin
            check_addr(req_addr, ref_pc, "instr_addr_o");
        end
        if (exp_inst_q.size() != 0 && dec_ready) begin // decode takes the head
            e_inst = exp_inst_q.pop_front();
            e_addr = exp_addr_q.pop_front();
            e_aj   = exp_aj_q.pop_front();
            e_int  = exp_int_q.pop_front();
            check_inst(inst, e_inst, "inst_o");
            check_addr(inst_addr, e_addr, "inst_addr_o");
            check_bit(after_jump, e_aj, "after_jump_o");
            check_int(int_flag, e_int, "int_flag_o");
            delivered++;
            if (e_aj) begin
                aj_seen++;
            end
        end
        if (exp_req && mem_ready) begin // accept, fields sampled now
            exp_inst_q.push_back(ref_pc ^ WORD_MASK);
            exp_addr_q.push_back(ref_pc);
            exp_aj_q.push_back(ref_aj);
            exp_int_q.push_back(irq);
            ref_pc = ref_pc + 32'd4;
            ref_aj = 1'b0;
        end
        if (jump || hold == HOLD_CLEAR) begin
            exp_inst_q.delete();
            exp_addr_q.delete();
            exp_aj_q.delete();
            exp_int_q.delete();
        end
        if (jump) begin
            ref_pc = jump_addr;
            ref_aj = 1'b1;
        end
    endtask

    task automatic run_cycle(input hold_e h, input logic j, input addr_t t,
                             input logic [1:0] d, input logic m, input int idx);
        logic [31:0] r;
        @(posedge clk);
        #1;
        r         = lcg_next();
        hold      = h;
        jump      = j;
        jump_addr = t;
        mem_ready = m ? r[20] : 1'b1;
        irq       = r[15:8];
        case (d)
            DEC_LOW:  dec_ready = 1'b0;
            DEC_HIGH: dec_ready = 1'b1;
            DEC_ALT:  dec_ready = idx[0];
            default:  dec_ready = r[27];
        endcase
        // pc is settled here, memory answers in the same cycle
        mem_rdata = mem_ready ? (req_addr ^ WORD_MASK) : 32'h0BAD_0BAD;
        @(negedge clk);
        check_cycle();
    endtask

    task automatic apply_reset();
        int i;
        rst = 1'b1;
        for (i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            if (i == 2) begin
                rst = 1'b0; // last negedge below is the boot cycle
            end
            @(negedge clk);
            check_bit(req, 1'b0, "instr_req_o in reset/boot");
            check_bit(valid, 1'b0, "valid_o in reset/boot");
        end
    endtask

    // stall fetching and let decode take whatever is left
    task automatic drain_buffer();
        int n;
        n = 0;
        while (exp_inst_q.size() != 0) begin
            if (n == DRAIN_MAX) begin
                fail_stop("timeout: buffer did not drain with decode ready");
            end
            run_cycle(HOLD_PC, 1'b0, '0, DEC_HIGH, 1'b0, n);
            n++;
        end
        run_cycle(HOLD_PC, 1'b0, '0, DEC_HIGH, 1'b0, n); // valid must be low now
    endtask

    initial begin
        int r;
        int c;
        rst       = 1'b1;
        hold      = HOLD_NONE;
        jump      = 1'b0;
        jump_addr = '0;
        irq       = '0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        dec_ready = 1'b0;
        lcg_state = 32'd78003;
        ref_pc    = RESET_PC;
        ref_aj    = 1'b0;
        delivered = 0;
        aj_seen   = 0;
        load_table();
        apply_reset();
        for (r = 0; r < N_ROWS; r++) begin
            for (c = 0; c < row_cycles[r]; c++) begin
                run_cycle(row_hold[r], row_jump[r] && (c == 0), row_target[r],
                          row_dec[r], row_mem_rand[r], c);
            end
        end
        drain_buffer();
        if (aj_seen == 2 && delivered >= 40) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_stop($sformatf("too little traffic: %0d entries, %0d jump targets",
                                delivered, aj_seen));
        end
    end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
/* instruction fetch front end top
   controller, program counter and decode buffer between memory and decode */

`default_nettype none

module fetch_unit (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire fetch_pkg::hold_e    hold_i,
    input  wire logic                jump_i,
    input  wire fetch_pkg::addr_t    jump_addr_i,
    input  wire fetch_pkg::int_vec_t int_i,
    input  wire logic                instr_ready_i,
    input  wire fetch_pkg::inst_t    instr_rdata_i,
    input  wire logic                ready_i,
    output logic                     instr_req_o,
    output fetch_pkg::addr_t         instr_addr_o,
    output logic                     valid_o,
    output fetch_pkg::inst_t         inst_o,
    output fetch_pkg::addr_t         inst_addr_o,
    output logic                     after_jump_o,
    output fetch_pkg::int_vec_t      int_flag_o
);

    import fetch_pkg::*;

    logic  fetch_en;
    logic  load_pc;
    logic  flush;
    logic  accept;    // req and ready both high
    addr_t pc;
    logic  pc_after_jump;

    assign instr_addr_o = pc; // request address is the live pc

    fetch_ctrl u_ctrl (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .hold_i    (hold_i),
        .jump_i    (jump_i),
        .fetch_en_o(fetch_en),
        .load_pc_o (load_pc),
        .flush_o   (flush)
    );

    pc_counter u_pc (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .advance_i   (accept),
        .load_i      (load_pc),
        .target_i    (jump_addr_i),
        .pc_o        (pc),
        .after_jump_o(pc_after_jump)
    );

    if_id u_if_id (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .fetch_en_i   (fetch_en),
        .flush_i      (flush),
        .instr_ready_i(instr_ready_i),
        .inst_i       (instr_rdata_i),
        .pc_i         (pc),
        .after_jump_i (pc_after_jump),
        .int_i        (int_i),      // sampled at accept
        .ready_i      (ready_i),
        .instr_req_o  (instr_req_o),
        .accept_o     (accept),
        .valid_o      (valid_o),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .after_jump_o (after_jump_o),
        .int_flag_o   (int_flag_o)
    );

endmodule

`default_nettype wire

// ==== source/fetch_ctrl.sv ====
/* fetch controller FSM
   turns reset, hold codes and jumps into fetch enable, pc load and flush */

`default_nettype none

module fetch_ctrl (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire fetch_pkg::hold_e hold_i,  // from later stages
    input  wire logic             jump_i,  // one-cycle redirect pulse
    output logic                  fetch_en_o,
    output logic                  load_pc_o,
    output logic                  flush_o
);

    import fetch_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        redirect; // jump or clear request

    assign redirect = jump_i || (hold_i == HOLD_CLEAR);

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_BOOT: begin
                state_d = CTRL_FETCH; // one idle cycle after reset
            end
            CTRL_FETCH: begin
                if (hold_i == HOLD_PC) begin
                    state_d = CTRL_HOLD;
                end
            end
            CTRL_HOLD: begin
                if (hold_i != HOLD_PC) begin
                    state_d = CTRL_FETCH; // release
                end
            end
            default: begin
                state_d = CTRL_BOOT;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= CTRL_BOOT;
        end else begin
            state_q <= state_d;
        end
    end

    // outputs follow state and inputs without a register
    always_comb begin
        fetch_en_o = 1'b0;
        load_pc_o  = 1'b0;
        flush_o    = 1'b0;
        case (state_q)
            CTRL_FETCH, CTRL_HOLD: begin
                fetch_en_o = (hold_i == HOLD_NONE) && !jump_i; // stall drops req at once
                load_pc_o  = jump_i;
                flush_o    = redirect;
            end
            default: begin
                fetch_en_o = 1'b0; // boot, buffer already empty
            end
        endcase
    end

    // a redirect drops the buffer, skips the fetch and lasts a single cycle
    a_load_flush: assert property (@(posedge clk_i) disable iff (rst_i)
        load_pc_o |=> $past(flush_o) && !$past(fetch_en_o) && !load_pc_o);

endmodule

`default_nettype wire

// ==== source/pc_counter.sv ====
/* fetch program counter
   steps by one word per accepted fetch, loads jump targets */

`default_nettype none

`include "fetch_config.svh"

module pc_counter (
    input  wire logic             clk_i,
    input  wire logic             rst_i,
    input  wire logic             advance_i, // fetch accepted this cycle
    input  wire logic             load_i,    // redirect
    input  wire fetch_pkg::addr_t target_i,
    output fetch_pkg::addr_t      pc_o,
    output logic                  after_jump_o
);

    import fetch_pkg::*;

    addr_t pc_q;
    logic  after_jump_q; // next fetch is the jump target

    assign pc_o         = pc_q;
    assign after_jump_o = after_jump_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q <= addr_t'(`FETCH_RESET_ADDR);
        end else if (load_i) begin
            pc_q <= target_i;            // redirect wins over advance
        end else if (advance_i) begin
            pc_q <= pc_q + addr_t'(4);   // next word
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            after_jump_q <= 1'b0;
        end else if (load_i) begin
            after_jump_q <= 1'b1;
        end else if (advance_i) begin
            after_jump_q <= 1'b0; // target fetched, flag done
        end
    end

    // jump targets come from outside, so check alignment here
    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        pc_q[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== source/if_id.sv ====
/* fetch-to-decode pipeline buffer
   packs word, address, jump flag and irq lines into a small FIFO */

`default_nettype none

`include "fetch_config.svh"

module if_id (
    input  wire logic                clk_i,
    input  wire logic                rst_i,
    input  wire logic                fetch_en_i,    // from controller
    input  wire logic                flush_i,       // jump or HOLD_CLEAR
    input  wire logic                instr_ready_i, // memory answers this cycle
    input  wire fetch_pkg::inst_t    inst_i,
    input  wire fetch_pkg::addr_t    pc_i,          // address of inst_i
    input  wire logic                after_jump_i,
    input  wire fetch_pkg::int_vec_t int_i,
    input  wire logic                ready_i,       // decode can take one
    output logic                     instr_req_o,
    output logic                     accept_o,      // fetch handshake done
    output logic                     valid_o,
    output fetch_pkg::inst_t         inst_o,
    output fetch_pkg::addr_t         inst_addr_o,
    output logic                     after_jump_o,
    output fetch_pkg::int_vec_t      int_flag_o
);

    import fetch_pkg::*;

    localparam int PACK_W = $bits(inst_t) + $bits(addr_t) + 1 + $bits(int_vec_t);

    logic full;
    logic empty;

    assign instr_req_o = fetch_en_i && !full; // back-pressure stops requests
    assign accept_o    = instr_req_o && instr_ready_i;
    assign valid_o     = !empty;

    fetch_fifo #(
        .DATA_W(PACK_W),
        .DEPTH (`FETCH_BUF_DEPTH)
    ) u_fifo (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .flush_i(flush_i),
        .push_i (accept_o),
        .data_i ({inst_i, pc_i, after_jump_i, int_i}),
        .pop_i  (valid_o && ready_i), // decode handshake
        .data_o ({inst_o, inst_addr_o, after_jump_o, int_flag_o}),
        .full_o (full),
        .empty_o(empty)
    );

endmodule

`default_nettype wire

// ==== source/fetch_fifo.sv ====
/* circular FIFO with registered output and flush
   read/write pointers plus occupancy count drive full and empty */

`default_nettype none

module fetch_fifo #(
    parameter int DATA_W = 8,
    parameter int DEPTH  = 2
) (
    input  wire logic              clk_i,
    input  wire logic              rst_i,
    input  wire logic              flush_i, // drop all entries at next edge
    input  wire logic              push_i,
    input  wire logic [DATA_W-1:0] data_i,
    input  wire logic              pop_i,
    output logic      [DATA_W-1:0] data_o,
    output logic                   full_o,
    output logic                   empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1; // keep ptr at least 1 bit
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_W-1:0] mem_q [DEPTH]; // payload storage
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [CNT_W-1:0]  count_q;       // entries held
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;  // overflow dropped
    assign do_pop  = pop_i && !empty_o;  // underflow ignored
    assign data_o  = mem_q[rd_ptr_q];    // not fall-through

    // pointer wrap at DEPTH, works for non power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i; // storage written even in flush cycle, harmless
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + CNT_W'(1);
                2'b01:   count_q <= count_q - CNT_W'(1);
                default: count_q <= count_q; // both or neither
            endcase
        end
    end

    // the producer must respect full, the consumer must respect empty
    a_no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
        push_i |-> !full_o);
    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
        pop_i |-> !empty_o);
    a_flush_empties: assert property (@(posedge clk_i) disable iff (rst_i)
        flush_i |=> empty_o);

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
/* fetch subsystem types
   word, address and interrupt vectors plus controller and hold encodings */

`default_nettype none

package fetch_pkg;

    `include "fetch_config.svh"

    typedef logic [`FETCH_INST_W-1:0] inst_t;    // one instruction word
    typedef logic [`FETCH_ADDR_W-1:0] addr_t;    // one instruction address
    typedef logic [`FETCH_INT_W-1:0]  int_vec_t; // external irq lines

    // hold request from later pipeline stages
    typedef enum logic [1:0] {
        HOLD_NONE  = 2'b00, // keep fetching
        HOLD_PC    = 2'b01, // freeze pc, keep buffered entries
        HOLD_CLEAR = 2'b10  // drop buffer, no fetch this cycle
    } hold_e;

    // fetch controller state
    typedef enum logic [1:0] {
        CTRL_BOOT  = 2'b00, // out of reset, no requests yet
        CTRL_FETCH = 2'b01, // normal streaming
        CTRL_HOLD  = 2'b10  // stalled by HOLD_PC
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== include/fetch_config.svh ====
/* fetch front end configuration
   reset vector, decode buffer depth and datapath widths */

`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// first fetch address after reset
`define FETCH_RESET_ADDR 32'h0000_0100

// entries in the fetch-to-decode buffer
`define FETCH_BUF_DEPTH 2

// instruction address width
`define FETCH_ADDR_W 32

// instruction word width
`define FETCH_INST_W 32

// external interrupt lines
`define FETCH_INT_W 8

`endif
